//--- decodePkg.sv
`default_nettype none

package decodePkg;

	// ====================
	// Instruction format
	// ====================

	// One instruction is a single 32-bit word
	localparam int instrWidth = 32;

	// Opcode sits in the top six bits
	localparam int opMsb = 31;
	localparam int opLsb = 26;

	// Destination register field
	localparam int rdMsb = 25;
	localparam int rdLsb = 21;

	// First source register field
	localparam int rs1Msb = 20;
	localparam int rs1Lsb = 16;

	// Second source register field, the immediate fills bits 10 to 0 below it
	localparam int rs2Msb = 15;
	localparam int rs2Lsb = 11;

	// Raw instruction word
	typedef logic [instrWidth-1:0] instr_t;

	// Opcode field on its own
	typedef logic [opMsb-opLsb:0] opcode_t;

	// Any register number, rd, rs1 or rs2
	typedef logic [rdMsb-rdLsb:0] regNum_t;

	// Memory access size of a load
	typedef logic [1:0] memSize_t;

	// Access size codes
	localparam memSize_t sizeByte = 2'd0;
	localparam memSize_t sizeWyde = 2'd1;
	localparam memSize_t sizeTetra = 2'd2;
	// Generic load, the real size is picked later from the immediate
	localparam memSize_t sizeGeneric = 2'd3;

	// ====================
	// Opcode table
	// ====================

	// No operation
	localparam opcode_t OP_NOP = 6'h00;

	// ALU, register form
	localparam opcode_t OP_ADD = 6'h01;
	localparam opcode_t OP_SUB = 6'h02;
	localparam opcode_t OP_AND = 6'h03;
	localparam opcode_t OP_OR = 6'h04;

	// ALU, immediate form
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_ANDI = 6'h09;

	// Load family, a Z suffix means zero extension
	localparam opcode_t OP_LDB = 6'h10;
	localparam opcode_t OP_LDBZ = 6'h11;
	localparam opcode_t OP_LDW = 6'h12;
	localparam opcode_t OP_LDWZ = 6'h13;
	localparam opcode_t OP_LDT = 6'h14;
	localparam opcode_t OP_LDTZ = 6'h15;
	localparam opcode_t OP_LOAD = 6'h16;

	// Atomic load-fetch
	localparam opcode_t OP_ALDF = 6'h17;

	// Conditional branches, then the jumps
	localparam opcode_t OP_BEQ = 6'h20;
	localparam opcode_t OP_BNE = 6'h21;
	localparam opcode_t OP_BLT = 6'h22;
	localparam opcode_t OP_BGE = 6'h23;
	localparam opcode_t OP_JMP = 6'h24;
	localparam opcode_t OP_JAL = 6'h25;
	localparam opcode_t OP_JALR = 6'h26;

endpackage

`default_nettype wire

//--- decodeIf.sv
`timescale 1ns/100ps
`default_nettype none

// Decoded record of one instruction, built by three decoders side by side
interface decodeIf (
	input wire logic clk
);

	// Load attributes
	logic isLoad;
	logic isAldf;
	decodePkg::memSize_t memSize;
	logic zeroExt;

	// Control flow attributes
	logic isBranch;
	logic isCond;
	logic isLink;

	// Operand fields and register usage
	decodePkg::regNum_t rd;
	decodePkg::regNum_t rs1;
	decodePkg::regNum_t rs2;
	logic rdWrite;
	logic rs2Read;
	logic illegal;

	// The clock only reaches the decoders that check themselves
	modport loadSide (input clk, output isLoad, isAldf, memSize, zeroExt);
	modport branchSide (input clk, output isBranch, isCond, isLink);
	modport operandSide (output rd, rs1, rs2, rdWrite, rs2Read, illegal);

	// Output register view, reads the whole record
	modport stageSide (
		input isLoad, isAldf, memSize, zeroExt,
		input isBranch, isCond, isLink,
		input rd, rs1, rs2, rdWrite, rs2Read, illegal
	);

endinterface

`default_nettype wire

//--- decodeLoad.sv
`timescale 1ns/100ps
`default_nettype none

module decodeLoad (
	input wire decodePkg::instr_t instr,
	decodeIf.loadSide dec
);

	decodePkg::opcode_t opcode;

	assign opcode = instr[decodePkg::opMsb:decodePkg::opLsb];

	// Membership in the load family, ALDF is a separate class
	always_comb
	begin
		case (opcode)
			decodePkg::OP_LDB, decodePkg::OP_LDBZ, decodePkg::OP_LDW, decodePkg::OP_LDWZ,
			decodePkg::OP_LDT, decodePkg::OP_LDTZ, decodePkg::OP_LOAD:
				dec.isLoad = 1'b1;
			default:
				dec.isLoad = 1'b0;
		endcase
	end

	assign dec.isAldf = (opcode == decodePkg::OP_ALDF);

	// Access size follows the letter in the mnemonic
	// Anything that is not a load reports byte, the field is don't-care then
	always_comb
	begin
		case (opcode)
			decodePkg::OP_LDW, decodePkg::OP_LDWZ:
				dec.memSize = decodePkg::sizeWyde;
			decodePkg::OP_LDT, decodePkg::OP_LDTZ, decodePkg::OP_ALDF:
				dec.memSize = decodePkg::sizeTetra;
			decodePkg::OP_LOAD:
				dec.memSize = decodePkg::sizeGeneric;
			default:
				dec.memSize = decodePkg::sizeByte;
		endcase
	end

	// Only the Z forms clear the upper bits, everything else sign extends
	assign dec.zeroExt = (opcode == decodePkg::OP_LDBZ) || (opcode == decodePkg::OP_LDWZ) ||
		(opcode == decodePkg::OP_LDTZ);

	// The memory unit treats load and atomic fetch as distinct requests
	loadAldfExclusive: assert property (@(posedge dec.clk) !(dec.isLoad && dec.isAldf))
		else $error("decodeLoad: isLoad and isAldf high together");

endmodule

`default_nettype wire

//--- decodeBranch.sv
`timescale 1ns/100ps
`default_nettype none

module decodeBranch (
	input wire decodePkg::instr_t instr,
	decodeIf.branchSide dec
);

	decodePkg::opcode_t opcode;

	assign opcode = instr[decodePkg::opMsb:decodePkg::opLsb];

	// Flow change class, split into condition and link
	always_comb
	begin
		dec.isBranch = 1'b0;
		dec.isCond = 1'b0;
		dec.isLink = 1'b0;
		case (opcode)
			// Compare-and-branch forms
			decodePkg::OP_BEQ, decodePkg::OP_BNE, decodePkg::OP_BLT, decodePkg::OP_BGE:
			begin
				dec.isBranch = 1'b1;
				dec.isCond = 1'b1;
			end
			// Plain jump, nothing saved
			decodePkg::OP_JMP:
				dec.isBranch = 1'b1;
			// Jumps that save the return address in rd
			decodePkg::OP_JAL, decodePkg::OP_JALR:
			begin
				dec.isBranch = 1'b1;
				dec.isLink = 1'b1;
			end
			default:
				dec.isBranch = 1'b0;
		endcase
	end

	// A linking jump is always unconditional
	condLinkExclusive: assert property (@(posedge dec.clk) !(dec.isCond && dec.isLink))
		else $error("decodeBranch: isCond and isLink high together");

endmodule

`default_nettype wire

//--- decodeOperands.sv
`timescale 1ns/100ps
`default_nettype none

module decodeOperands (
	input wire decodePkg::instr_t instr,
	decodeIf.operandSide dec
);

	decodePkg::opcode_t opcode;
	// Opcode class flags, before the rd and legality gating
	logic writesRd;
	logic readsRs2;
	logic known;

	assign opcode = instr[decodePkg::opMsb:decodePkg::opLsb];

	// Register fields are passed on as they are, whether used or not
	assign dec.rd = instr[decodePkg::rdMsb:decodePkg::rdLsb];
	assign dec.rs1 = instr[decodePkg::rs1Msb:decodePkg::rs1Lsb];
	assign dec.rs2 = instr[decodePkg::rs2Msb:decodePkg::rs2Lsb];

	// ====================
	// Opcode classes
	// ====================

	always_comb
	begin
		writesRd = 1'b0;
		readsRs2 = 1'b0;
		known = 1'b1;
		case (opcode)
			decodePkg::OP_NOP:
				known = 1'b1;
			// Register-register ALU reads both sources and writes rd
			decodePkg::OP_ADD, decodePkg::OP_SUB, decodePkg::OP_AND, decodePkg::OP_OR:
			begin
				writesRd = 1'b1;
				readsRs2 = 1'b1;
			end
			// Immediate ALU forms and every load only write rd
			decodePkg::OP_ADDI, decodePkg::OP_ANDI,
			decodePkg::OP_LDB, decodePkg::OP_LDBZ, decodePkg::OP_LDW, decodePkg::OP_LDWZ,
			decodePkg::OP_LDT, decodePkg::OP_LDTZ, decodePkg::OP_LOAD, decodePkg::OP_ALDF:
				writesRd = 1'b1;
			// Conditional branches compare rs1 with rs2
			decodePkg::OP_BEQ, decodePkg::OP_BNE, decodePkg::OP_BLT, decodePkg::OP_BGE:
				readsRs2 = 1'b1;
			// Plain jump uses rs1 only
			decodePkg::OP_JMP:
				known = 1'b1;
			// Linking jumps put the return address in rd
			decodePkg::OP_JAL, decodePkg::OP_JALR:
				writesRd = 1'b1;
			default:
				known = 1'b0;
		endcase
	end

	assign dec.illegal = !known;

	// Register 0 is hardwired, a write to it is dropped here
	assign dec.rdWrite = writesRd && known && (dec.rd != '0);
	assign dec.rs2Read = readsRs2 && known;

endmodule

`default_nettype wire

//--- decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
	input wire logic clk,
	input wire logic rst,
	input wire logic instrValid,
	input wire decodePkg::instr_t instr,
	output logic outValid,
	output logic isLoad,
	output logic isAldf,
	output decodePkg::memSize_t memSize,
	output logic zeroExt,
	output logic isBranch,
	output logic isCond,
	output logic isLink,
	output decodePkg::regNum_t rd,
	output decodePkg::regNum_t rs1,
	output decodePkg::regNum_t rs2,
	output logic rdWrite,
	output logic rs2Read,
	output logic illegal
);

	// Captured instruction and its strobe
	decodePkg::instr_t instrQ;
	logic validQ;

	// ====================
	// Input register
	// ====================

	// The word is taken every cycle and the output register drops it when its strobe was low
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			instrQ <= '0;
			validQ <= 1'b0;
		end
		else
		begin
			validQ <= instrValid;
			instrQ <= instr;
		end
	end

	// ====================
	// Decoders
	// ====================

	decodeIf decBus (.clk(clk));

	decodeLoad loadDec_i (
		.instr(instrQ),
		.dec(decBus.loadSide)
	);

	decodeBranch branchDec_i (
		.instr(instrQ),
		.dec(decBus.branchSide)
	);

	decodeOperands operandDec_i (
		.instr(instrQ),
		.dec(decBus.operandSide)
	);

	// ====================
	// Output register
	// ====================

	// Fields only update with a valid word and hold through gaps
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outValid <= 1'b0;
			isLoad <= 1'b0;
			isAldf <= 1'b0;
			memSize <= decodePkg::sizeByte;
			zeroExt <= 1'b0;
			isBranch <= 1'b0;
			isCond <= 1'b0;
			isLink <= 1'b0;
			rd <= '0;
			rs1 <= '0;
			rs2 <= '0;
			rdWrite <= 1'b0;
			rs2Read <= 1'b0;
			illegal <= 1'b0;
		end
		else
		begin
			outValid <= validQ;
			if (validQ)
			begin
				isLoad <= decBus.isLoad;
				isAldf <= decBus.isAldf;
				memSize <= decBus.memSize;
				zeroExt <= decBus.zeroExt;
				isBranch <= decBus.isBranch;
				isCond <= decBus.isCond;
				isLink <= decBus.isLink;
				rd <= decBus.rd;
				rs1 <= decBus.rs1;
				rs2 <= decBus.rs2;
				rdWrite <= decBus.rdWrite;
				rs2Read <= decBus.rs2Read;
				illegal <= decBus.illegal;
			end
		end
	end

	// Each output strobe goes back to an accepted word two edges earlier
	outValidOrigin: assert property (@(posedge clk) disable iff (rst)
		outValid |-> $past(instrValid, 2))
		else $error("decodeStage: outValid without instrValid two edges before");

endmodule

`default_nettype wire

//--- decodeChecker.sv
`timescale 1ns/100ps
`default_nettype none

module decodeChecker (
	input wire logic clk,
	input wire logic rst,
	input wire logic instrValid,
	input wire decodePkg::instr_t instr,
	input wire logic outValid,
	input wire logic isLoad,
	input wire logic isAldf,
	input wire decodePkg::memSize_t memSize,
	input wire logic zeroExt,
	input wire logic isBranch,
	input wire logic isCond,
	input wire logic isLink,
	input wire decodePkg::regNum_t rd,
	input wire decodePkg::regNum_t rs1,
	input wire decodePkg::regNum_t rs2,
	input wire logic rdWrite,
	input wire logic rs2Read,
	input wire logic illegal,
	output int testCount,
	output int errorCount,
	output int checkCount
);

	// Words sampled at the DUT input, oldest first
	decodePkg::instr_t instrQueue[$];
	bit validQueue[$];
	bit armed = 1'b0;
	bit inReset = 1'b0;
	bit resetBad = 1'b0;
	bit entryBad;
	int tests = 0;
	int errors = 0;
	int checks = 0;

	// Expected record, it holds its value through gaps like the DUT register
	logic exValid;
	logic exIsLoad;
	logic exIsAldf;
	decodePkg::memSize_t exMemSize;
	logic exZeroExt;
	logic exIsBranch;
	logic exIsCond;
	logic exIsLink;
	decodePkg::regNum_t exRd;
	decodePkg::regNum_t exRs1;
	decodePkg::regNum_t exRs2;
	logic exRdWrite;
	logic exRs2Read;
	logic exIllegal;

	assign testCount = tests;
	assign errorCount = errors;
	assign checkCount = checks;

	// ====================
	// Reference decode
	// ====================

	task automatic predict(input decodePkg::instr_t w);
		decodePkg::opcode_t op;
		logic aluReg;
		logic aluImm;
		op = w[decodePkg::opMsb:decodePkg::opLsb];
		exRd = w[decodePkg::rdMsb:decodePkg::rdLsb];
		exRs1 = w[decodePkg::rs1Msb:decodePkg::rs1Lsb];
		exRs2 = w[decodePkg::rs2Msb:decodePkg::rs2Lsb];
		exIsLoad = op inside {[decodePkg::OP_LDB:decodePkg::OP_LOAD]};
		exIsAldf = (op == decodePkg::OP_ALDF);
		exZeroExt = op inside {decodePkg::OP_LDBZ, decodePkg::OP_LDWZ, decodePkg::OP_LDTZ};
		exIsBranch = op inside {[decodePkg::OP_BEQ:decodePkg::OP_JALR]};
		exIsCond = op inside {[decodePkg::OP_BEQ:decodePkg::OP_BGE]};
		exIsLink = op inside {decodePkg::OP_JAL, decodePkg::OP_JALR};
		aluReg = op inside {[decodePkg::OP_ADD:decodePkg::OP_OR]};
		aluImm = op inside {decodePkg::OP_ADDI, decodePkg::OP_ANDI};
		exIllegal = !((op == decodePkg::OP_NOP) || aluReg || aluImm || exIsLoad || exIsAldf ||
			exIsBranch);
		// r0 never gets written
		exRdWrite = (aluReg || aluImm || exIsLoad || exIsAldf || exIsLink) && (exRd != '0);
		exRs2Read = aluReg || exIsCond;
		case (op)
			decodePkg::OP_LDW, decodePkg::OP_LDWZ:
				exMemSize = 2'd1;
			decodePkg::OP_LDT, decodePkg::OP_LDTZ, decodePkg::OP_ALDF:
				exMemSize = 2'd2;
			decodePkg::OP_LOAD:
				exMemSize = 2'd3;
			default:
				exMemSize = 2'd0;
		endcase
	endtask

	task automatic clearExpected;
		exValid = 1'b0;
		predict(32'h0);
	endtask

	task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			entryBad = 1'b1;
			$display("[FAIL] %0d ns: entry %0d, %s is %0h, expected %0h",
				$time, tests + 1, name, got, exp);
		end
	endtask

	task automatic compareRecord;
		checkField("outValid", 32'(outValid), 32'(exValid));
		checkField("isLoad", 32'(isLoad), 32'(exIsLoad));
		checkField("isAldf", 32'(isAldf), 32'(exIsAldf));
		// Size only means something for a memory read
		if (exIsLoad || exIsAldf)
			checkField("memSize", 32'(memSize), 32'(exMemSize));
		checkField("zeroExt", 32'(zeroExt), 32'(exZeroExt));
		checkField("isBranch", 32'(isBranch), 32'(exIsBranch));
		checkField("isCond", 32'(isCond), 32'(exIsCond));
		checkField("isLink", 32'(isLink), 32'(exIsLink));
		checkField("rd", 32'(rd), 32'(exRd));
		checkField("rs1", 32'(rs1), 32'(exRs1));
		checkField("rs2", 32'(rs2), 32'(exRs2));
		checkField("rdWrite", 32'(rdWrite), 32'(exRdWrite));
		checkField("rs2Read", 32'(rs2Read), 32'(exRs2Read));
		checkField("illegal", 32'(illegal), 32'(exIllegal));
	endtask

	// ====================
	// Sampling
	// ====================

	// Outputs seen at an edge belong to the word sampled two edges before
	always @(posedge clk)
	begin : sample
		decodePkg::instr_t oldInstr;
		bit oldValid;
		bit popped;
		popped = 1'b0;
		oldInstr = '0;
		oldValid = 1'b0;
		if (armed)
		begin
			entryBad = 1'b0;
			exValid = 1'b0;
			if (instrQueue.size() == 2)
			begin
				oldInstr = instrQueue.pop_front();
				oldValid = validQueue.pop_front();
				popped = 1'b1;
				exValid = oldValid;
				if (oldValid)
					predict(oldInstr);
			end
			compareRecord();
			if (inReset)
				resetBad = resetBad || entryBad;
			if (popped)
			begin
				tests++;
				$display("Entry %0d, instr %h, valid %0b: %s", tests, oldInstr, oldValid,
					entryBad ? "mismatch" : "ok");
			end
			else if (inReset && !rst)
				$display("Reset state: %s", resetBad ? "mismatch" : "ok");
		end
		if (rst)
		begin
			instrQueue.delete();
			validQueue.delete();
			clearExpected();
			armed = 1'b1;
			inReset = 1'b1;
		end
		else
		begin
			inReset = 1'b0;
			instrQueue.push_back(instr);
			validQueue.push_back(instrValid);
		end
	end

endmodule

`default_nettype wire

//--- decodeTb.sv
`timescale 1ns/100ps
`default_nettype none

module decodeTb;

	localparam int clkPeriod = 20;
	localparam int resetCycles = 16;

	logic clk;
	logic rst;
	logic instrValid;
	decodePkg::instr_t instr;

	logic outValid;
	logic isLoad;
	logic isAldf;
	decodePkg::memSize_t memSize;
	logic zeroExt;
	logic isBranch;
	logic isCond;
	logic isLink;
	decodePkg::regNum_t rd;
	decodePkg::regNum_t rs1;
	decodePkg::regNum_t rs2;
	logic rdWrite;
	logic rs2Read;
	logic illegal;

	int testCount;
	int errorCount;
	int checkCount;

	// Stimulus table with one instruction word and its strobe per entry
	decodePkg::instr_t instrTable[$];
	bit validTable[$];
	int seed = 47981;

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Register fields and immediate are random and the opcode is forced on top
	task automatic addEntry(input decodePkg::opcode_t op, input bit valid, input bit zeroRd);
		decodePkg::instr_t word;
		word = $random(seed);
		word[decodePkg::opMsb:decodePkg::opLsb] = op;
		if (zeroRd)
			word[decodePkg::rdMsb:decodePkg::rdLsb] = '0;
		instrTable.push_back(word);
		validTable.push_back(valid);
	endtask

	task automatic buildTable;
		// Whole load family back to back and then a load aimed at r0
		addEntry(decodePkg::OP_LDB, 1'b1, 1'b0);
		addEntry(decodePkg::OP_LDBZ, 1'b1, 1'b0);
		addEntry(decodePkg::OP_LDW, 1'b1, 1'b0);
		addEntry(decodePkg::OP_LDWZ, 1'b1, 1'b0);
		addEntry(decodePkg::OP_LDT, 1'b1, 1'b0);
		addEntry(decodePkg::OP_LDTZ, 1'b1, 1'b0);
		addEntry(decodePkg::OP_LOAD, 1'b1, 1'b0);
		addEntry(decodePkg::OP_LDB, 1'b1, 1'b1);
		// ALDF followed by a single idle slot
		addEntry(decodePkg::OP_ALDF, 1'b1, 1'b0);
		addEntry(decodePkg::OP_ADD, 1'b0, 1'b0);
		// Conditional branches, plain jump and both linking jumps
		addEntry(decodePkg::OP_BEQ, 1'b1, 1'b0);
		addEntry(decodePkg::OP_BNE, 1'b1, 1'b0);
		addEntry(decodePkg::OP_BLT, 1'b1, 1'b0);
		addEntry(decodePkg::OP_BGE, 1'b1, 1'b0);
		addEntry(decodePkg::OP_JMP, 1'b1, 1'b0);
		addEntry(decodePkg::OP_JAL, 1'b1, 1'b0);
		addEntry(decodePkg::OP_JALR, 1'b1, 1'b0);
		addEntry(decodePkg::OP_JAL, 1'b1, 1'b1);
		// Two idle slots whose words on the bus must be ignored
		addEntry(decodePkg::OP_SUB, 1'b0, 1'b0);
		addEntry(decodePkg::OP_LDT, 1'b0, 1'b0);
		// Holes in the opcode map
		addEntry(6'h05, 1'b1, 1'b0);
		addEntry(6'h18, 1'b1, 1'b0);
		addEntry(6'h27, 1'b1, 1'b0);
		addEntry(6'h3F, 1'b1, 1'b0);
		// ALU forms with one of them aimed at r0 and then NOP
		addEntry(decodePkg::OP_ADD, 1'b1, 1'b0);
		addEntry(decodePkg::OP_SUB, 1'b1, 1'b0);
		addEntry(decodePkg::OP_AND, 1'b1, 1'b0);
		addEntry(decodePkg::OP_OR, 1'b1, 1'b0);
		addEntry(decodePkg::OP_ADDI, 1'b1, 1'b0);
		addEntry(decodePkg::OP_ANDI, 1'b1, 1'b0);
		addEntry(decodePkg::OP_ADD, 1'b1, 1'b1);
		addEntry(decodePkg::OP_NOP, 1'b1, 1'b0);
		// Alternating strobe
		addEntry(decodePkg::OP_LDWZ, 1'b1, 1'b0);
		addEntry(decodePkg::OP_JALR, 1'b0, 1'b0);
		addEntry(decodePkg::OP_BEQ, 1'b1, 1'b0);
		addEntry(decodePkg::OP_OR, 1'b0, 1'b0);
		addEntry(decodePkg::OP_ALDF, 1'b1, 1'b0);
	endtask

	decodeStage dut_i (
		.clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
		.outValid(outValid), .isLoad(isLoad), .isAldf(isAldf), .memSize(memSize),
		.zeroExt(zeroExt), .isBranch(isBranch), .isCond(isCond), .isLink(isLink),
		.rd(rd), .rs1(rs1), .rs2(rs2), .rdWrite(rdWrite), .rs2Read(rs2Read), .illegal(illegal)
	);

	decodeChecker check_i (
		.clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
		.outValid(outValid), .isLoad(isLoad), .isAldf(isAldf), .memSize(memSize),
		.zeroExt(zeroExt), .isBranch(isBranch), .isCond(isCond), .isLink(isLink),
		.rd(rd), .rs1(rs1), .rs2(rs2), .rdWrite(rdWrite), .rs2Read(rs2Read), .illegal(illegal),
		.testCount(testCount), .errorCount(errorCount), .checkCount(checkCount)
	);

	initial
	begin
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		buildTable();
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
		// One entry per edge and the DUT samples it at the following edge
		for (int i = 0; i < instrTable.size(); i++)
		begin
			instrValid <= validTable[i];
			instr <= instrTable[i];
			@(posedge clk);
		end
		instrValid <= 1'b0;
		// Every entry leaves the pipe two edges after it was sampled
		while (testCount < instrTable.size())
			@(negedge clk);
		$display("Entries: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Limit covers reset, the table and a generous drain
	initial
	begin : watchdog
		int limitNs;
		#1;
		limitNs = (instrTable.size() + resetCycles + 20) * clkPeriod;
		#(limitNs - 1);
		$display("Timeout: the run did not finish within %0d ns", limitNs);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- decode.f
decodePkg.sv
decodeIf.sv
decodeLoad.sv
decodeBranch.sv
decodeOperands.sv
decodeStage.sv
decodeChecker.sv
decodeTb.sv

//--- run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module decodeTb -f decode.f -o decodeSim &&
./obj_dir/decodeSim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
